/* hdl/erx_defines.svh */
`ifndef ERX_DEFINES_SVH
`define ERX_DEFINES_SVH

// upper 12 bits of every address this node owns
`define ERX_NODE_ID 12'h808

// column id is the low 6 bits of the node id
`define ERX_COL_ID 6'd8
`define ERX_COL_SHIFT 3 // clog2 of the column id

`define ERX_PW 104 // full mesh word

// config register addresses
`define ERX_REG_CTRL 2'd0
`define ERX_REG_STATIC 2'd1
`define ERX_REG_BASE 2'd2
`define ERX_REG_DROPS 2'd3 // read only

`endif

/* hdl/emesh_pkg.sv */
`default_nettype none

// mesh packet format as it arrives from the link
package emesh_pkg;

   // control byte at the bottom of the packet
   typedef struct packed
   {
      logic [4:0] ctrlmode;
      logic [1:0] datamode;
      logic write; // 0 = read request
   } emesh_ctrl_t;

   // single word access with source address over data
   typedef struct packed
   {
      logic [31:0] src_addr;
      logic [31:0] data;
   } emesh_single_t;

   // upper 64 bits mean different things per datamode
   typedef union packed
   {
      emesh_single_t single;
      logic [63:0] double_word; // double-word writes
   } emesh_payload_t;

   // 104 bit mesh word with the payload in the top bits
   typedef struct packed
   {
      emesh_payload_t payload;
      logic [31:0] dst_addr;
      emesh_ctrl_t ctrl;
   } emesh_packet_t;

endpackage

`default_nettype wire

/* hdl/erx_cfg_pkg.sv */
`default_nettype none

// receive path configuration types
package erx_cfg_pkg;

   // code 2'b11 is not named and is treated as continuity
   typedef enum logic [1:0]
   {
      REMAP_NONE = 2'b00,
      REMAP_STATIC = 2'b01,
      REMAP_CONT = 2'b10
   } remap_mode_t;

   // everything the remap and protect stages need
   typedef struct packed
   {
      remap_mode_t mode;
      logic protect_en;
      logic [11:0] sel; // 1 = take bit from pattern
      logic [11:0] pattern;
      logic [31:0] base; // continuity remap offset
   } remap_cfg_t;

endpackage

`default_nettype wire

/* hdl/erx_cfg.sv */
`timescale 1ns/1ps
`default_nettype none

`include "erx_defines.svh"

// small register block holding the remap and protect setup
module erx_cfg
(
   input wire logic clk,
   input wire logic rst_n,

   // register write port
   input wire logic cfg_write,
   input wire logic [1:0] cfg_addr,
   input wire logic [31:0] cfg_wdata,

   // status from the protect stage
   input wire logic [15:0] drop_count,

   output logic [31:0] cfg_rdata,
   output erx_cfg_pkg::remap_cfg_t cfg
);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         cfg <= '0; // mode none and protection off
      end
      else if (cfg_write)
      begin
         case (cfg_addr)
            `ERX_REG_CTRL:
            begin
               cfg.mode <= erx_cfg_pkg::remap_mode_t'(cfg_wdata[1:0]);
               cfg.protect_en <= cfg_wdata[2];
            end
            `ERX_REG_STATIC:
            begin
               cfg.sel <= cfg_wdata[11:0];
               cfg.pattern <= cfg_wdata[27:16];
            end
            `ERX_REG_BASE:
            begin
               cfg.base <= cfg_wdata;
            end
            default:
            begin
               // drops register ignores writes
            end
         endcase
      end
   end

   // readback with fields at their write positions
   always_comb
   begin
      case (cfg_addr)
         `ERX_REG_CTRL:
         begin
            cfg_rdata = {29'd0, cfg.protect_en, cfg.mode};
         end
         `ERX_REG_STATIC:
         begin
            cfg_rdata = {4'd0, cfg.pattern, 4'd0, cfg.sel};
         end
         `ERX_REG_BASE:
         begin
            cfg_rdata = cfg.base;
         end
         default:
         begin
            cfg_rdata = {16'd0, drop_count};
         end
      endcase
   end

endmodule

`default_nettype wire

/* hdl/erx_remap.sv */
`timescale 1ns/1ps
`default_nettype none

`include "erx_defines.svh"

// destination address rewrite in one register stage
module erx_remap
(
   input wire logic clk,
   input wire logic rst_n,

   input wire logic in_access,
   input wire emesh_pkg::emesh_packet_t in_packet,

   input wire erx_cfg_pkg::remap_cfg_t cfg,
   input wire logic wait_in, // stalls the stage

   output logic out_access,
   output emesh_pkg::emesh_packet_t out_packet
);

   // column offset removed before adding the base back
   localparam logic [31:0] col_offset = 32'(`ERX_COL_ID) << 20;

   logic [31:0] addr_in;
   logic [31:0] static_addr;
   logic [31:0] cont_addr;
   logic [31:0] remap_addr;
   emesh_pkg::emesh_packet_t remap_packet;

   assign addr_in = in_packet.dst_addr;

   // per bit substitution in the upper 12 bits
   assign static_addr[31:20] = (cfg.sel & cfg.pattern) | (~cfg.sel & addr_in[31:20]);
   assign static_addr[19:0] = addr_in[19:0];

   // compressed map that wraps modulo 2^32
   assign cont_addr = addr_in - col_offset + cfg.base
                      - (32'(addr_in[31:26]) << `ERX_COL_SHIFT);

   always_comb
   begin
      if (cfg.mode == erx_cfg_pkg::REMAP_NONE || !in_packet.ctrl.write)
      begin
         remap_addr = addr_in; // reads bypass the remap
      end
      else if (cfg.mode == erx_cfg_pkg::REMAP_STATIC)
      begin
         remap_addr = static_addr;
      end
      else
      begin
         remap_addr = cont_addr; // continuity and the unnamed code 3
      end
   end

   always_comb
   begin
      remap_packet = in_packet;
      remap_packet.dst_addr = remap_addr;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         out_access <= 1'b0;
      end
      else if (!wait_in)
      begin
         out_access <= in_access;
      end
   end

   // packet register
   always_ff @(posedge clk)
   begin
      if (!wait_in)
      begin
         out_packet <= remap_packet;
      end
   end

endmodule

`default_nettype wire

/* hdl/erx_protect.sv */
`timescale 1ns/1ps
`default_nettype none

`include "erx_defines.svh"

// drops packets addressed outside this node and counts them
module erx_protect
(
   input wire logic clk,
   input wire logic rst_n,

   input wire logic in_access,
   input wire emesh_pkg::emesh_packet_t in_packet,

   input wire logic protect_en,
   input wire logic wait_in,

   output logic out_access,
   output emesh_pkg::emesh_packet_t out_packet,
   output logic protect_error, // one pulse per drop
   output logic [15:0] drop_count
);

   logic foreign;
   logic drop;

   assign foreign = in_packet.dst_addr[31:20] != `ERX_NODE_ID;
   assign drop = in_access & protect_en & foreign;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         out_access <= 1'b0;
         protect_error <= 1'b0;
      end
      else if (!wait_in)
      begin
         out_access <= in_access & ~drop;
         protect_error <= drop;
      end
   end

   // saturating drop counter that holds during a stall
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         drop_count <= '0;
      end
      else if (!wait_in && drop && drop_count != '1)
      begin
         drop_count <= drop_count + 16'd1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!wait_in)
      begin
         out_packet <= in_packet; // dropped packets still load while access stays low
      end
   end

endmodule

`default_nettype wire

/* hdl/erx_path.sv */
`timescale 1ns/1ps
`default_nettype none

// receive path remap slice with config block, remap stage and window check
module erx_path
(
   input wire logic clk,
   input wire logic rst_n,

   // config register port
   input wire logic cfg_write,
   input wire logic [1:0] cfg_addr,
   input wire logic [31:0] cfg_wdata,
   output logic [31:0] cfg_rdata,

   // from the link
   input wire logic rx_access,
   input wire emesh_pkg::emesh_packet_t rx_packet,
   output logic rx_wait,

   // towards the core
   output logic tx_access,
   output emesh_pkg::emesh_packet_t tx_packet,
   input wire logic tx_wait,

   output logic protect_error
);

   erx_cfg_pkg::remap_cfg_t cfg;
   logic [15:0] drop_count;
   logic remap_access;
   emesh_pkg::emesh_packet_t remap_packet;

   // one stall level for both stages and the source
   assign rx_wait = tx_wait;

   erx_cfg erx_cfg_i
   (
      .clk (clk),
      .rst_n (rst_n),
      .cfg_write (cfg_write),
      .cfg_addr (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .drop_count (drop_count),
      .cfg_rdata (cfg_rdata),
      .cfg (cfg)
   );

   erx_remap erx_remap_i
   (
      .clk (clk),
      .rst_n (rst_n),
      .in_access (rx_access),
      .in_packet (rx_packet),
      .cfg (cfg),
      .wait_in (tx_wait),
      .out_access (remap_access),
      .out_packet (remap_packet)
   );

   erx_protect erx_protect_i
   (
      .clk (clk),
      .rst_n (rst_n),
      .in_access (remap_access),
      .in_packet (remap_packet),
      .protect_en (cfg.protect_en),
      .wait_in (tx_wait),
      .out_access (tx_access),
      .out_packet (tx_packet),
      .protect_error (protect_error),
      .drop_count (drop_count)
   );

endmodule

`default_nettype wire

/* bench/erx_path_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "erx_defines.svh"

module erx_path_tb;

   localparam int MAX_VEC = 32;
   localparam int NFIELD = 8; // words per vector line

   // word offsets inside one vector
   localparam int F_TEST = 0;
   localparam int F_CTRL = 1;
   localparam int F_STATIC = 2;
   localparam int F_BASE = 3;
   localparam int F_IN = 4;
   localparam int F_ACC = 5;
   localparam int F_OUT = 6;
   localparam int F_ERR = 7;

   logic clk;
   logic rst_n;
   logic cfg_write;
   logic [1:0] cfg_addr;
   logic [31:0] cfg_wdata;
   logic [31:0] cfg_rdata;
   logic rx_access;
   emesh_pkg::emesh_packet_t rx_packet;
   logic rx_wait;
   logic tx_access;
   emesh_pkg::emesh_packet_t tx_packet;
   logic tx_wait;
   logic protect_error;

   logic [`ERX_PW-1:0] vec_mem [0:MAX_VEC*NFIELD-1];
   int nvec;
   int err_count;
   int tests_passed;
   int tests_failed;
   int errs_at_last_test;
   int exp_drops; // drops expected so far over both runs
   int cycles = 0;
   int cycle_limit;
   logic [15:0] lfsr;

   erx_path erx_path_i
   (
      .clk (clk),
      .rst_n (rst_n),
      .cfg_write (cfg_write),
      .cfg_addr (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg_rdata (cfg_rdata),
      .rx_access (rx_access),
      .rx_packet (rx_packet),
      .rx_wait (rx_wait),
      .tx_access (tx_access),
      .tx_packet (tx_packet),
      .tx_wait (tx_wait),
      .protect_error (protect_error)
   );

   always #10 clk = ~clk;

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit)
      begin
         $display("timeout, the run did not finish within %0d cycles", cycle_limit);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic same_config(input int a, input int b);
      return vec_mem[a*NFIELD+F_CTRL] == vec_mem[b*NFIELD+F_CTRL]
         && vec_mem[a*NFIELD+F_STATIC] == vec_mem[b*NFIELD+F_STATIC]
         && vec_mem[a*NFIELD+F_BASE] == vec_mem[b*NFIELD+F_BASE];
   endfunction

   task automatic compare(input string name, input logic [`ERX_PW-1:0] got,
                          input logic [`ERX_PW-1:0] expected);
      if (got !== expected)
      begin
         $display("Fail %s: got %h expected %h", name, got, expected);
         err_count++;
      end
   endtask

   task automatic finish_test(input string label);
      if (err_count == errs_at_last_test)
      begin
         tests_passed++;
         $display("%s: ok", label);
      end
      else
      begin
         tests_failed++;
         $display("%s: failed with %0d errors", label, err_count - errs_at_last_test);
      end
      errs_at_last_test = err_count;
   endtask

   task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
      @(posedge clk);
      cfg_write <= 1'b1;
      cfg_addr <= addr;
      cfg_wdata <= data;
      tx_wait <= 1'b0;
      rx_access <= 1'b0;
   endtask

   // combinational readback checked at the falling edge
   task automatic read_reg(input logic [1:0] addr, input logic [31:0] expected,
                           input string name);
      @(posedge clk);
      cfg_write <= 1'b0;
      cfg_addr <= addr;
      tx_wait <= 1'b0;
      rx_access <= 1'b0;
      @(negedge clk);
      compare($sformatf("cfg_rdata %s", name), 104'(cfg_rdata), 104'(expected));
   endtask

   task automatic configure(input int v);
      logic [31:0] ctrl;
      logic [31:0] stat;
      logic [31:0] base;
      ctrl = vec_mem[v*NFIELD+F_CTRL][31:0];
      stat = vec_mem[v*NFIELD+F_STATIC][31:0];
      base = vec_mem[v*NFIELD+F_BASE][31:0];
      write_reg(`ERX_REG_CTRL, ctrl);
      write_reg(`ERX_REG_STATIC, stat);
      write_reg(`ERX_REG_BASE, base);
      read_reg(`ERX_REG_CTRL, ctrl & 32'h0000_0007, "ctrl readback");
      read_reg(`ERX_REG_STATIC, stat & 32'h0FFF_0FFF, "static readback");
      read_reg(`ERX_REG_BASE, base, "base readback");
   endtask

   // back to back packets sharing one config with optional random stalls
   task automatic run_burst(input int first, input int count, input logic stall,
                            input int run);
      int sent;
      int done;
      int s1;
      int s2;
      int cur_idx;
      int b;
      logic cur_wait;
      logic cur_acc;
      logic edge_wait;
      logic prev_acc;
      logic prev_err;
      logic [`ERX_PW-1:0] prev_pkt;
      sent = 0;
      done = 0;
      s1 = -1; // remap stage contents
      s2 = -1; // output stage contents
      cur_idx = -1;
      cur_wait = 1'b0;
      cur_acc = 1'b0;
      prev_acc = tx_access;
      prev_err = protect_error;
      prev_pkt = tx_packet;
      while (done < count)
      begin
         @(posedge clk);
         edge_wait = cur_wait;
         if (!edge_wait)
         begin
            s2 = s1;
            s1 = cur_acc ? cur_idx : -1;
         end
         if (stall)
         begin
            lfsr = lfsr_step(lfsr);
            cur_wait = lfsr[0];
         end
         else
         begin
            cur_wait = 1'b0;
         end
         tx_wait <= cur_wait;
         cur_acc = sent < count;
         rx_access <= cur_acc;
         if (cur_acc)
         begin
            cur_idx = first + sent;
            rx_packet <= vec_mem[cur_idx*NFIELD+F_IN]; // held again while stalled
            if (!cur_wait)
            begin
               sent++;
            end
         end
         @(negedge clk);
         compare("rx_wait", 104'(rx_wait), 104'(cur_wait));
         if (edge_wait)
         begin
            compare("tx_access", 104'(tx_access), 104'(prev_acc));
            compare("protect_error", 104'(protect_error), 104'(prev_err));
            compare("tx_packet", tx_packet, prev_pkt);
         end
         else if (s2 >= 0)
         begin
            b = s2 * NFIELD;
            compare("tx_access", 104'(tx_access), vec_mem[b+F_ACC]);
            compare("protect_error", 104'(protect_error), vec_mem[b+F_ERR]);
            if (vec_mem[b+F_ACC][0])
            begin
               compare("tx_packet", tx_packet, vec_mem[b+F_OUT]);
            end
            if (vec_mem[b+F_ERR][0])
            begin
               exp_drops++;
            end
            finish_test($sformatf("run %0d test %0d", run, vec_mem[b+F_TEST][7:0]));
            done++;
         end
         else
         begin
            compare("tx_access", 104'(tx_access), 104'(0));
            compare("protect_error", 104'(protect_error), 104'(0));
         end
         prev_acc = tx_access;
         prev_err = protect_error;
         prev_pkt = tx_packet;
      end
   endtask

   initial
   begin
      int i;
      int v;
      int n;
      int run;
      clk = 1'b0;
      rst_n <= 1'b0;
      cfg_write <= 1'b0;
      cfg_addr <= 2'd0;
      cfg_wdata <= 32'd0;
      rx_access <= 1'b0;
      rx_packet <= '0;
      tx_wait <= 1'b0;
      err_count = 0;
      tests_passed = 0;
      tests_failed = 0;
      errs_at_last_test = 0;
      exp_drops = 0;
      lfsr = 16'd93;
      for (i = 0; i < MAX_VEC * NFIELD; i++)
      begin
         vec_mem[i] = '0;
      end
      $readmemh("bench/erx_path_patterns.hex", vec_mem);
      nvec = 0;
      while (nvec < MAX_VEC && vec_mem[nvec*NFIELD+F_TEST] != '0)
      begin
         nvec++;
      end
      cycle_limit = 8 + 40 * nvec; // reset plus a budget per vector
      if (nvec == 0)
      begin
         $display("no vectors were found in the pattern file");
         err_count++;
      end
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      compare("tx_access", 104'(tx_access), 104'(0));
      compare("protect_error", 104'(protect_error), 104'(0));
      read_reg(`ERX_REG_CTRL, 32'd0, "ctrl after reset");
      read_reg(`ERX_REG_STATIC, 32'd0, "static after reset");
      read_reg(`ERX_REG_BASE, 32'd0, "base after reset");
      read_reg(`ERX_REG_DROPS, 32'd0, "drops after reset");
      finish_test("reset");
      // run 0 without stalls and run 1 with random stalls
      for (run = 0; run < 2; run++)
      begin
         v = 0;
         while (v < nvec)
         begin
            n = 1;
            while (v + n < nvec && same_config(v, v + n))
            begin
               n++;
            end
            configure(v);
            run_burst(v, n, run == 1, run);
            read_reg(`ERX_REG_DROPS, 32'(exp_drops), "drops readback");
            v += n;
         end
      end
      $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
      if (err_count == 0 && tests_failed == 0)
      begin
         $display("ALL TESTS PASSED");
      end
      else
      begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* bench/erx_path_patterns.hex */
// test ctrl static base in_packet exp_access exp_packet exp_error
// packet = payload(16 hex) dst_addr(8 hex) ctrl(2 hex), vectors with equal config run back to back
// mode none, single, read and double word
01 00000000 00000000 00000000 AAAA0001DEADBEEF1234567805 1 AAAA0001DEADBEEF1234567805 0
02 00000000 00000000 00000000 80800F00000000008080100004 1 80800F00000000008080100004 0
03 00000000 00000000 00000000 0123456789ABCDEFFFFFFFFC07 1 0123456789ABCDEFFFFFFFFC07 0
// static, sel ff0 pattern 808
04 00000001 08080FF0 00000000 AAAA0002CAFEF00D1234567805 1 AAAA0002CAFEF00D8034567805 0
05 00000001 08080FF0 00000000 FEDCBA9876543210ABCDE00407 1 FEDCBA987654321080CDE00407 0
06 00000001 08080FF0 00000000 AAAA0003000000001234567804 1 AAAA0003000000001234567804 0
// static, sel fff, unused register bits set
07 FFFFFFF9 F808FFFF 00000000 11112222333344440000000005 1 11112222333344448080000005 0
08 FFFFFFF9 F808FFFF 00000000 5555666677778888FFFFFFFF45 1 5555666677778888808FFFFF45 0
// continuity, base 80800000
09 00000002 00000000 80800000 AAAA0004123456780081234505 1 AAAA0004123456788081234505 0
0A 00000002 00000000 80800000 0F0F0F0FF0F0F0F00481234007 1 0F0F0F0FF0F0F0F08481233807 0
0B 00000002 00000000 80800000 AAAA000500000011FC80010005 1 AAAA0005000000117C7FFF0805 0
0C 00000002 00000000 80800000 AAAA0006000000001234567804 1 AAAA0006000000001234567804 0
// mode code 3, base 0, wraps below zero
0D 00000003 00000000 00000000 AAAA0007000000220000000405 1 AAAA000700000022FF80000405 0
0E 00000003 00000000 00000000 AAAA0008000000330880000005 1 AAAA00080000003307FFFFF005 0
// protection on, mode none
0F 00000004 00000000 00000000 AAAA0009000000448081234505 1 AAAA0009000000448081234505 0
10 00000004 00000000 00000000 AAAA000A000000551234567805 0 AAAA000A000000551234567805 1
11 00000004 00000000 00000000 AAAA000B000000008090000004 0 AAAA000B000000008090000004 1
12 00000004 00000000 00000000 AAAA000C00000066808FFFFF05 1 AAAA000C00000066808FFFFF05 0
// protection with static remap
13 00000005 08080FFF 00000000 AAAA000D000000771234567805 1 AAAA000D000000778084567805 0
14 00000005 08080FFF 00000000 AAAA000E000000001234567804 0 AAAA000E000000001234567804 1
// protection with continuity remap
15 00000006 00000000 80800000 AAAA000F000000880081234505 1 AAAA000F000000888081234505 0
16 00000006 00000000 80800000 AAAA0010000000990481234005 0 AAAA0010000000998481233805 1

/* flist.f */
+incdir+hdl
hdl/emesh_pkg.sv
hdl/erx_cfg_pkg.sv
hdl/erx_cfg.sv
hdl/erx_remap.sv
hdl/erx_protect.sv
hdl/erx_path.sv
bench/erx_path_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the receive path testbench with verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f flist.f \
   --top-module erx_path_tb -o erx_sim &&
./obj_dir/erx_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "simulation passed" ||
{
   echo "simulation failed"
   exit 1
}
